/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_hdc_top
DUT_TOP    ?= hdc_top
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only
JOBS       ?= 0

RTL_SRCS := $(filter src/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) --top-module $(DUT_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* src/hdc_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface hdc_ctrl_if;

    import hdc_pkg::*;

    // levels from the register block
    logic              gen;
    logic              run;
    logic [item_w-1:0] item_count;

    // single-cycle completion pulses
    logic              gen_done;
    logic              run_done;

    modport regs (
        output gen,
        output run,
        output item_count,
        input  gen_done,
        input  run_done
    );

    modport gen_side (
        input  gen,
        input  item_count,
        output gen_done
    );

    modport stream_side (
        input  run,
        output run_done
    );

endinterface

`default_nettype wire

/* src/hdc_pkg.sv */
`default_nettype none

package hdc_pkg;

    // ========================================================================
    // bus and datapath widths
    // ========================================================================
    localparam int axil_addr_w = 12;
    localparam int axil_data_w = 32;
    localparam int prng_w      = 32;
    localparam int axis_data_w = 64;
    localparam int item_w      = 16;

    // reload value of the item memory prng
    localparam logic [prng_w-1:0] xorshift_seed = 32'd2463534242;

    // ========================================================================
    // register map, byte offsets
    // ========================================================================
    typedef enum logic [axil_addr_w-1:0] {
        reg_ctrl       = 12'h000,
        reg_item_count = 12'h004
    } reg_addr_t;

    // bit positions inside reg_ctrl
    localparam int ctrl_gen_bit = 0;
    localparam int ctrl_run_bit = 1;

    // axi-lite slave states
    typedef enum logic [2:0] {
        st_idle,
        st_aw,
        st_w,
        st_resp,
        st_rd_addr,
        st_rd_data
    } axil_state_t;

    // stream master states
    typedef enum logic [1:0] {
        st_wait,
        st_send,
        st_hold
    } stream_state_t;

endpackage

`default_nettype wire

/* src/hdc_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module hdc_regs (
    input  logic                            AXIS_ACLK,
    input  logic                            S_AXI_ARESETN,
    input  logic [hdc_pkg::axil_addr_w-1:0] s_axi_awaddr,
    input  logic                            s_axi_awvalid,
    output logic                            s_axi_awready,
    input  logic [hdc_pkg::axil_data_w-1:0] s_axi_wdata,
    input  logic                            s_axi_wvalid,
    output logic                            s_axi_wready,
    output logic                            s_axi_bvalid,
    input  logic                            s_axi_bready,
    input  logic [hdc_pkg::axil_addr_w-1:0] s_axi_araddr,
    input  logic                            s_axi_arvalid,
    output logic                            s_axi_arready,
    output logic [hdc_pkg::axil_data_w-1:0] s_axi_rdata,
    output logic                            s_axi_rvalid,
    input  logic                            s_axi_rready,
    hdc_ctrl_if.regs                        ctrl
);

    import hdc_pkg::*;

    axil_state_t            state;
    logic                   wr_pend;
    logic [axil_addr_w-1:0] wr_addr;
    logic [axil_data_w-1:0] wr_data;
    logic [axil_addr_w-1:0] rd_addr;
    logic [axil_addr_w-1:0] wr_off;
    logic [axil_addr_w-1:0] rd_off;
    logic [axil_data_w-1:0] rd_word;
    logic                   gen_q;
    logic                   run_q;
    logic [item_w-1:0]      item_count_q;

    // ========================================================================
    // axi-lite handshake
    // ========================================================================
    assign s_axi_awready = (state == st_idle) || (state == st_w);
    assign s_axi_wready  = (state == st_idle) || (state == st_aw);
    // a pending write wins over a read in the same cycle
    assign s_axi_arready = (state == st_idle) && !s_axi_awvalid && !s_axi_wvalid;
    assign s_axi_bvalid  = (state == st_resp);
    assign s_axi_rvalid  = (state == st_rd_data);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state   <= st_idle;
            wr_pend <= 1'b0;
        end else begin
            wr_pend <= 1'b0;
            case (state)
                st_idle: begin
                    if (s_axi_awvalid && s_axi_wvalid) begin
                        state   <= st_resp;
                        wr_pend <= 1'b1;
                    end else if (s_axi_awvalid) begin
                        state <= st_aw;
                    end else if (s_axi_wvalid) begin
                        state <= st_w;
                    end else if (s_axi_arvalid) begin
                        state <= st_rd_addr;
                    end
                end
                st_aw: begin
                    if (s_axi_wvalid) begin
                        state   <= st_resp;
                        wr_pend <= 1'b1;
                    end
                end
                st_w: begin
                    if (s_axi_awvalid) begin
                        state   <= st_resp;
                        wr_pend <= 1'b1;
                    end
                end
                st_resp: begin
                    if (s_axi_bready) begin
                        state <= st_idle;
                    end
                end
                st_rd_addr: state <= st_rd_data;
                st_rd_data: begin
                    if (s_axi_rready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // address and data latches
    always_ff @(posedge AXIS_ACLK) begin
        if (s_axi_awvalid && s_axi_awready) begin
            wr_addr <= s_axi_awaddr;
        end
        if (s_axi_wvalid && s_axi_wready) begin
            wr_data <= s_axi_wdata;
        end
        if (s_axi_arvalid && s_axi_arready) begin
            rd_addr <= s_axi_araddr;
        end
        if (state == st_rd_addr) begin
            s_axi_rdata <= rd_word;
        end
    end

    // word aligned offsets
    assign wr_off = {wr_addr[axil_addr_w-1:2], 2'b00};
    assign rd_off = {rd_addr[axil_addr_w-1:2], 2'b00};

    // ========================================================================
    // register file
    // ========================================================================
    always_comb begin
        rd_word = '0;
        case (rd_off)
            reg_ctrl: begin
                rd_word[ctrl_run_bit] = run_q;
                rd_word[ctrl_gen_bit] = gen_q;
            end
            reg_item_count: rd_word[item_w-1:0] = item_count_q;
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen_q        <= 1'b0;
            run_q        <= 1'b0;
            item_count_q <= '0;
        end else begin
            if (wr_pend && (wr_off == reg_ctrl)) begin
                run_q <= wr_data[ctrl_run_bit];
                gen_q <= wr_data[ctrl_gen_bit];
            end else begin
                // self clear once the block reports done
                if (ctrl.gen_done) begin
                    gen_q <= 1'b0;
                end
                if (ctrl.run_done) begin
                    run_q <= 1'b0;
                end
            end
            if (wr_pend && (wr_off == reg_item_count)) begin
                item_count_q <= wr_data[item_w-1:0];
            end
        end
    end

    assign ctrl.gen        = gen_q;
    assign ctrl.run        = run_q;
    assign ctrl.item_count = item_count_q;

endmodule

`default_nettype wire

/* src/hdc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hdc_top #(
    parameter int DIM = 1024
) (
    input  logic                            AXIS_ACLK,
    input  logic                            S_AXI_ARESETN,

    // axi-lite slave
    input  logic [hdc_pkg::axil_addr_w-1:0] s_axi_awaddr,
    input  logic                            s_axi_awvalid,
    output logic                            s_axi_awready,
    input  logic [hdc_pkg::axil_data_w-1:0] s_axi_wdata,
    input  logic                            s_axi_wvalid,
    output logic                            s_axi_wready,
    output logic                            s_axi_bvalid,
    input  logic                            s_axi_bready,
    input  logic [hdc_pkg::axil_addr_w-1:0] s_axi_araddr,
    input  logic                            s_axi_arvalid,
    output logic                            s_axi_arready,
    output logic [hdc_pkg::axil_data_w-1:0] s_axi_rdata,
    output logic                            s_axi_rvalid,
    input  logic                            s_axi_rready,

    // axi-stream master
    output logic [hdc_pkg::axis_data_w-1:0] m_axis_tdata,
    output logic                            m_axis_tvalid,
    output logic                            m_axis_tlast,
    input  logic                            m_axis_tready
);

    // DIM is expected to be a multiple of 64
    logic [DIM-1:0] item_vector;

    hdc_ctrl_if ctrl ();

    // ========================================================================
    // control registers
    // ========================================================================
    hdc_regs i_regs (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .ctrl          (ctrl.regs)
    );

    // item memory generation
    item_memory_gen #(
        .DIM (DIM)
    ) i_gen (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .ctrl          (ctrl.gen_side),
        .item_vector   (item_vector)
    );

    // stream out of the captured vector
    vector_streamer #(
        .DIM (DIM)
    ) i_streamer (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .ctrl          (ctrl.stream_side),
        .item_vector   (item_vector),
        .tdata         (m_axis_tdata),
        .tvalid        (m_axis_tvalid),
        .tlast         (m_axis_tlast),
        .tready        (m_axis_tready)
    );

endmodule

`default_nettype wire

/* src/item_memory_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module item_memory_gen #(
    parameter int DIM = 1024
) (
    input  logic                AXIS_ACLK,
    input  logic                S_AXI_ARESETN,
    hdc_ctrl_if.gen_side        ctrl,
    output logic [DIM-1:0]      item_vector
);

    import hdc_pkg::*;

    // prng words per hypervector
    localparam int                words     = DIM / prng_w;
    localparam int                word_w    = (words > 1) ? $clog2(words) : 1;
    localparam logic [word_w-1:0] last_word = word_w'(words - 1);

    logic [prng_w-1:0] rand_word;
    logic [word_w-1:0] word_cnt;
    logic [item_w-1:0] item_cnt;
    logic              item_done;
    logic [DIM-1:0]    asm_vec;
    logic              capture;
    logic              gen_done_q;

    xorshift32 i_prng (
        .AXIS_ACLK (AXIS_ACLK),
        .enable    (ctrl.gen),
        .rand_word (rand_word)
    );

    // ========================================================================
    // word and item counters
    // ========================================================================
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !ctrl.gen) begin
            word_cnt  <= '0;
            item_cnt  <= '0;
            item_done <= 1'b0;
        end else begin
            item_done <= (word_cnt == last_word);
            if (word_cnt == last_word) begin
                word_cnt <= '0;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
            // item index moves on one cycle after its last word
            if (item_done) begin
                item_cnt <= item_cnt + 1'b1;
            end
        end
    end

    // word j of the current item lands in bits 32j+31:32j
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !ctrl.gen) begin
            asm_vec <= '0;
        end else begin
            asm_vec[word_cnt*prng_w +: prng_w] <= rand_word;
        end
    end

    // ========================================================================
    // capture of the selected item
    // ========================================================================
    // asm_vec still holds the finished item while item_done is high
    assign capture = ctrl.gen && item_done && (item_cnt == ctrl.item_count);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            item_vector <= '0;
            gen_done_q  <= 1'b0;
        end else begin
            gen_done_q <= capture;
            if (capture) begin
                item_vector <= asm_vec;
            end
        end
    end

    assign ctrl.gen_done = gen_done_q;

endmodule

`default_nettype wire

/* src/vector_streamer.sv */
`timescale 1ns/1ps
`default_nettype none

module vector_streamer #(
    parameter int DIM = 1024
) (
    input  logic                            AXIS_ACLK,
    input  logic                            S_AXI_ARESETN,
    hdc_ctrl_if.stream_side                 ctrl,
    input  logic [DIM-1:0]                  item_vector,
    output logic [hdc_pkg::axis_data_w-1:0] tdata,
    output logic                            tvalid,
    output logic                            tlast,
    input  logic                            tready
);

    import hdc_pkg::*;

    // 64-bit beats per hypervector
    localparam int                beats     = DIM / axis_data_w;
    localparam int                beat_w    = (beats > 1) ? $clog2(beats) : 1;
    localparam logic [beat_w-1:0] last_beat = beat_w'(beats - 1);

    stream_state_t     state;
    logic [beat_w-1:0] beat_cnt;
    logic              beat_fire;
    logic              run_done_q;

    assign tvalid    = (state == st_send);
    assign tlast     = tvalid && (beat_cnt == last_beat);
    assign tdata     = item_vector[beat_cnt*axis_data_w +: axis_data_w];
    assign beat_fire = tvalid && tready;

    // ========================================================================
    // beat sequencing
    // ========================================================================
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state      <= st_wait;
            beat_cnt   <= '0;
            run_done_q <= 1'b0;
        end else begin
            run_done_q <= 1'b0;
            case (state)
                st_wait: begin
                    beat_cnt <= '0;
                    if (ctrl.run) begin
                        state <= st_send;
                    end
                end
                st_send: begin
                    // beat held as is until the sink takes it
                    if (beat_fire) begin
                        if (beat_cnt == last_beat) begin
                            state      <= st_hold;
                            run_done_q <= 1'b1;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                st_hold: begin
                    // wait for run to self-clear before rearming
                    if (!ctrl.run) begin
                        state <= st_wait;
                    end
                end
                default: state <= st_wait;
            endcase
        end
    end

    assign ctrl.run_done = run_done_q;

endmodule

`default_nettype wire

/* src/xorshift32.sv */
`timescale 1ns/1ps
`default_nettype none

module xorshift32 (
    input  logic                       AXIS_ACLK,
    input  logic                       enable,
    output logic [hdc_pkg::prng_w-1:0] rand_word
);

    import hdc_pkg::*;

    logic [prng_w-1:0] state_q;
    logic [prng_w-1:0] step_a;
    logic [prng_w-1:0] step_b;
    logic [prng_w-1:0] step_c;

    // shifts 13 left, 17 right, 5 left
    always_comb begin
        step_a = state_q ^ (state_q << 13);
        step_b = step_a ^ (step_a >> 17);
        step_c = step_b ^ (step_b << 5);
    end

    // output is the state the next edge will load,
    // so the first enabled cycle already sees step one
    assign rand_word = step_c;

    always_ff @(posedge AXIS_ACLK) begin
        if (!enable) begin
            state_q <= xorshift_seed;
        end else begin
            state_q <= step_c;
        end
    end

endmodule

`default_nettype wire

/* testbench/hdc_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module hdc_chk (
    input  logic                            AXIS_ACLK,
    input  logic                            S_AXI_ARESETN,
    input  logic [hdc_pkg::axis_data_w-1:0] m_axis_tdata,
    input  logic                            m_axis_tvalid,
    input  logic                            m_axis_tlast,
    input  logic                            m_axis_tready,
    input  logic                            s_axi_bvalid,
    input  logic                            s_axi_rvalid
);

    // beat frozen while the sink stalls
    a_beat_hold: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        (m_axis_tvalid && !m_axis_tready) |=>
            (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)))
        else $error("stream beat changed under back-pressure");

    a_last_valid: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        m_axis_tlast |-> m_axis_tvalid)
        else $error("tlast high without tvalid");

    // write response and read data never overlap
    a_resp_excl: assert property (@(posedge AXIS_ACLK) disable iff (!S_AXI_ARESETN)
        !(s_axi_bvalid && s_axi_rvalid))
        else $error("bvalid and rvalid high together");

endmodule

bind hdc_top hdc_chk i_chk (
    .AXIS_ACLK     (AXIS_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tready (m_axis_tready),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_rvalid  (s_axi_rvalid)
);

`default_nettype wire

/* testbench/tb_hdc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_hdc_top;

    import hdc_pkg::*;

    localparam int dim       = 256;
    localparam int words     = dim / prng_w;
    localparam int beats     = dim / axis_data_w;
    localparam int max_items = 40;
    // three generations plus four streams, each beat stalled at most 32 cycles
    localparam int watchdog_cycles = 3 * (max_items + 1) * words + 4 * beats * 32 + 3000;

    logic                   AXIS_ACLK;
    logic                   S_AXI_ARESETN;
    logic [axil_addr_w-1:0] s_axi_awaddr;
    logic                   s_axi_awvalid;
    logic                   s_axi_awready;
    logic [axil_data_w-1:0] s_axi_wdata;
    logic                   s_axi_wvalid;
    logic                   s_axi_wready;
    logic                   s_axi_bvalid;
    logic                   s_axi_bready;
    logic [axil_addr_w-1:0] s_axi_araddr;
    logic                   s_axi_arvalid;
    logic                   s_axi_arready;
    logic [axil_data_w-1:0] s_axi_rdata;
    logic                   s_axi_rvalid;
    logic                   s_axi_rready;
    logic [axis_data_w-1:0] m_axis_tdata;
    logic                   m_axis_tvalid;
    logic                   m_axis_tlast;
    logic                   m_axis_tready;

    logic [16:0]            lfsr_q = 17'd98093;
    logic                   stall_on = 1'b0;
    logic [31:0]            ready_mask = '1;
    logic [axis_data_w-1:0] exp_beats[$];
    logic                   exp_last[$];

    hdc_top #(
        .DIM (dim)
    ) i_dut (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tready (m_axis_tready)
    );

    initial begin
        AXIS_ACLK = 1'b0;
        forever #4 AXIS_ACLK = ~AXIS_ACLK;
    end

    // ========================================================================
    // random source and reference model
    // ========================================================================
    // 17-bit fibonacci lfsr, taps 17 and 14
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[16]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    function automatic logic [31:0] xorshift_next(input logic [31:0] s);
        logic [31:0] t;
        t = s ^ (s << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    // word j of item i is state number i*words + j + 1 after the seed
    function automatic logic [dim-1:0] ref_item_vector(input int item);
        logic [dim-1:0] v;
        logic [31:0]    s;
        int             n;
        s = 32'd2463534242;
        v = '0;
        for (n = 0; n < item * words; n++) begin
            s = xorshift_next(s);
        end
        for (n = 0; n < words; n++) begin
            s = xorshift_next(s);
            v[n*32 +: 32] = s;
        end
        return v;
    endfunction

    // ========================================================================
    // checks
    // ========================================================================
    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [axil_data_w-1:0] exp,
                              input logic [axil_data_w-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_beat(input string name, input logic [axis_data_w-1:0] exp,
                              input logic [axis_data_w-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
            stop_with_failure();
        end
    endtask

    // ========================================================================
    // bus tasks
    // ========================================================================
    task automatic axil_write(input logic [axil_addr_w-1:0] addr,
                              input logic [axil_data_w-1:0] data);
        s_axi_awaddr  <= addr;
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wvalid  <= 1'b1;
        s_axi_bready  <= 1'b1;
        @(posedge AXIS_ACLK);
        while (!(s_axi_awready && s_axi_wready)) @(posedge AXIS_ACLK);
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        @(posedge AXIS_ACLK);
        while (!s_axi_bvalid) @(posedge AXIS_ACLK);
        s_axi_bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [axil_addr_w-1:0] addr,
                             output logic [axil_data_w-1:0] data);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        @(posedge AXIS_ACLK);
        while (!s_axi_arready) @(posedge AXIS_ACLK);
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b1;
        @(posedge AXIS_ACLK);
        while (!s_axi_rvalid) @(posedge AXIS_ACLK);
        data = s_axi_rdata;
        s_axi_rready <= 1'b0;
    endtask

    task automatic expect_reg(input string name, input logic [axil_addr_w-1:0] addr,
                              input logic [axil_data_w-1:0] exp);
        logic [axil_data_w-1:0] v;
        axil_read(addr, v);
        check_word(name, exp, v);
    endtask

    // gen and run both self-clear, so ctrl reads zero once the block is done
    task automatic wait_ctrl_idle();
        logic [axil_data_w-1:0] v;
        axil_read(reg_ctrl, v);
        while (v != '0) axil_read(reg_ctrl, v);
    endtask

    task automatic generate_item(input int item);
        axil_write(reg_item_count, item);
        axil_write(reg_ctrl, 32'd1 << ctrl_gen_bit);
        wait_ctrl_idle();
    endtask

    task automatic stream_item(input int item);
        logic [dim-1:0] vec;
        int             k;
        vec = ref_item_vector(item);
        for (k = 0; k < beats; k++) begin
            exp_beats.push_back(vec[k*axis_data_w +: axis_data_w]);
            exp_last.push_back(k == beats - 1);
        end
        axil_write(reg_ctrl, 32'd1 << ctrl_run_bit);
        wait_ctrl_idle();
        if (exp_beats.size() != 0) begin
            $display("run cleared with %0d beats of item %0d never sent", exp_beats.size(), item);
            stop_with_failure();
        end
    endtask

    // ========================================================================
    // stream sink and compare
    // ========================================================================
    initial begin
        int idx;
        idx = 0;
        m_axis_tready <= 1'b1;
        forever begin
            @(posedge AXIS_ACLK);
            if (stall_on) begin
                m_axis_tready <= ready_mask[idx];
                idx = (idx + 1) % 32;
            end else begin
                m_axis_tready <= 1'b1;
            end
        end
    end

    always @(posedge AXIS_ACLK) begin
        if (S_AXI_ARESETN && m_axis_tvalid && m_axis_tready) begin
            if (exp_beats.size() == 0) begin
                $display("a beat was accepted at %0t ns while none was expected", $time);
                stop_with_failure();
            end else begin
                check_beat("m_axis_tdata", exp_beats.pop_front(), m_axis_tdata);
                check_beat("m_axis_tlast", axis_data_w'(exp_last.pop_front()),
                           axis_data_w'(m_axis_tlast));
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge AXIS_ACLK);
        $display("run timed out after %0d clock cycles", watchdog_cycles);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin
        logic [axil_data_w-1:0] val;
        int                     cnt_a;
        int                     cnt_b;
        S_AXI_ARESETN <= 1'b0;
        s_axi_awaddr  <= '0;
        s_axi_awvalid <= 1'b0;
        s_axi_wdata   <= '0;
        s_axi_wvalid  <= 1'b0;
        s_axi_bready  <= 1'b0;
        s_axi_araddr  <= '0;
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b0;
        repeat (4) @(posedge AXIS_ACLK);
        S_AXI_ARESETN <= 1'b1;
        @(posedge AXIS_ACLK);

        // reset values, stream idle
        repeat (4) begin
            @(posedge AXIS_ACLK);
            check_beat("m_axis_tvalid", '0, axis_data_w'(m_axis_tvalid));
        end
        expect_reg("reg_ctrl", reg_ctrl, '0);
        expect_reg("reg_item_count", reg_item_count, '0);

        // register readback and unmapped offset
        val = rand_bits(16);
        axil_write(reg_item_count, val);
        expect_reg("reg_item_count", reg_item_count, val);
        axil_write(12'h010, rand_bits(32));
        expect_reg("unmapped 0x010", 12'h010, '0);
        expect_reg("reg_item_count", reg_item_count, val);

        generate_item(0);
        stream_item(0);

        // random item under back-pressure, then the same vector again
        cnt_a = int'(rand_bits(6) % max_items);
        stall_on   <= 1'b1;
        ready_mask <= rand_bits(32) | 32'h1;
        generate_item(cnt_a);
        stream_item(cnt_a);
        stream_item(cnt_a);

        // a new generation replaces the captured vector
        cnt_b = int'(rand_bits(6) % max_items);
        if (cnt_b == cnt_a) begin
            cnt_b = (cnt_a + 1) % max_items;
        end
        generate_item(cnt_b);
        stream_item(cnt_b);

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
src/hdc_pkg.sv
src/hdc_ctrl_if.sv
src/hdc_regs.sv
src/xorshift32.sv
src/item_memory_gen.sv
src/vector_streamer.sv
src/hdc_top.sv
testbench/hdc_chk.sv
testbench/tb_hdc_top.sv
